//--- rtl/fixedPkg.sv
// Fixed-point number types and constants
// Three-component vector and 8-bit color types

package fixedPkg;

    // ------------------------------------------------
    // Scalar fixed point, 16.16 signed
    // ------------------------------------------------
    typedef logic signed [31:0] fixed_t;

    localparam int FixedFrac = 16;

    // Largest positive value, start distance of a search
    localparam fixed_t FixedMax = 32'sh7fff_ffff;

    // ------------------------------------------------
    // Vectors and colors
    // ------------------------------------------------
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef logic [7:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb8_t;

endpackage

//--- rtl/rasterPkg.sv
// Raster stage types: primitive groups, jobs, store slots,
// hit records and output fragments
// Scheduler state enum and global group constants

package rasterPkg;

    // ------------------------------------------------
    // Primitive indexing
    // ------------------------------------------------
    typedef logic [7:0] primIndex_t;
    typedef logic [3:0] primCount_t;

    typedef struct packed {
        primIndex_t start;
        primCount_t count;
    } primGroup_t;

    // Global group, always searched first
    localparam primIndex_t GlobalStart = 8'd0;
    localparam primCount_t GlobalCount = 4'd3;

    // ------------------------------------------------
    // Job and result records
    // ------------------------------------------------
    typedef struct packed {
        logic [9:0] pixelX;
        logic [9:0] pixelY;
        fixedPkg::vec3_t origin;
        fixedPkg::vec3_t direction;
        primGroup_t [1:0] leafGroups;
    } rasterJob_t;

    // One answer of the primitive store per batch slot
    typedef struct packed {
        logic hit;
        fixedPkg::fixed_t t;
        fixedPkg::rgb8_t color;
    } primSlot_t;

    typedef struct packed {
        logic hit;
        fixedPkg::fixed_t t;
        primIndex_t primIndex;
        fixedPkg::rgb8_t color;
    } hitRecord_t;

    typedef struct packed {
        logic [9:0] pixelX;
        logic [9:0] pixelY;
        logic hit;
        primIndex_t primIndex;
        fixedPkg::vec3_t hitPos;
        fixedPkg::rgb8_t color;
    } fragment_t;

    typedef enum logic [1:0] {
        Init,
        Rasterize,
        Done
    } rasterState_t;

endpackage

//--- rtl/primGroupQueue.sv
// Circular queue of primitive groups
// One push and one pop per cycle, head shown without a register stage

`timescale 1ns/1ns

module primGroupQueue #(
    parameter int QueueDepth = 4
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  pushEn,
    input  rasterPkg::primGroup_t pushGroup,
    input  logic                  popEn,
    output rasterPkg::primGroup_t headGroup,
    output logic                  empty
);
    import rasterPkg::*;

    localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

    typedef logic [PtrWidth-1:0] queuePtr_t;

    primGroup_t groups [QueueDepth];

    // Top is the oldest entry, bottom the next free one
    queuePtr_t top;
    queuePtr_t bottom;

    function automatic queuePtr_t nextPtr(queuePtr_t ptr);
        if (ptr == queuePtr_t'(QueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty     = (top == bottom);
    assign headGroup = groups[top];

    // ------------------------------------------------
    // Pointers
    // ------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            top    <= '0;
            bottom <= '0;
        end else begin
            if (pushEn) begin
                bottom <= nextPtr(bottom);
            end
            if (popEn) begin
                top <= nextPtr(top);
            end
        end
    end

    // Group storage
    always_ff @(posedge clk) begin
        if (pushEn) begin
            groups[bottom] <= pushGroup;
        end
    end

endmodule

//--- rtl/batchScheduler.sv
// One-entry job slot and job state machine
// Pushes the global and leaf groups, pops groups and walks
// each one in aligned batches of UnitSize primitives

`timescale 1ns/1ns

module batchScheduler #(
    parameter int UnitSize = 2
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  addInput,
    input  rasterPkg::rasterJob_t job,
    input  logic                  outputFifoFull,
    input  rasterPkg::primGroup_t headGroup,
    input  logic                  empty,
    output logic                  fifoFull,
    output rasterPkg::rasterJob_t curJob,
    output logic                  pushEn,
    output rasterPkg::primGroup_t pushGroup,
    output logic                  popEn,
    output logic                  jobStart,
    output logic                  batchValid,
    output rasterPkg::primIndex_t startPrimitive,
    output rasterPkg::primIndex_t endPrimitive,
    output logic                  finish
);
    import rasterPkg::*;

    localparam primIndex_t Step     = primIndex_t'(UnitSize);
    localparam primIndex_t UnitMask = primIndex_t'(UnitSize - 1);

    rasterState_t state;
    rasterJob_t slotJob;

    // 0 global, 1 leaf 0, 2 leaf 1, 3 all pushed
    logic [1:0] pushCount;
    logic takeJob;
    logic pushesDone;

    // Batch walk of the popped group
    primIndex_t curStart;
    primIndex_t alignedEnd;
    primIndex_t realEnd;
    primIndex_t headCount;
    primIndex_t alignedCount;

    assign takeJob    = addInput && !fifoFull;
    assign jobStart   = (state == Init) && fifoFull;
    assign pushesDone = (pushCount == 2'd3);

    // Count rounded up to a whole number of batches
    assign headCount    = primIndex_t'(headGroup.count);
    assign alignedCount = (headCount + UnitMask) & ~UnitMask;

    assign batchValid = (state == Rasterize) && (curStart != alignedEnd);
    assign popEn      = (state == Rasterize) && !batchValid && !empty;
    assign finish     = (state == Done) && !outputFifoFull;

    assign startPrimitive = curStart;
    assign endPrimitive   = realEnd;

    // ------------------------------------------------
    // Group pushes
    // ------------------------------------------------
    always_comb begin
        pushEn    = 1'b0;
        pushGroup = '{start: GlobalStart, count: GlobalCount};
        if (jobStart) begin
            pushEn = 1'b1;
        end else if (state == Rasterize) begin
            // Empty leaf groups are skipped
            if (pushCount == 2'd1) begin
                pushGroup = curJob.leafGroups[0];
                pushEn    = (curJob.leafGroups[0].count != '0);
            end else if (pushCount == 2'd2) begin
                pushGroup = curJob.leafGroups[1];
                pushEn    = (curJob.leafGroups[1].count != '0);
            end
        end
    end

    // ------------------------------------------------
    // Job slot and state machine
    // ------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= Init;
            fifoFull   <= 1'b0;
            pushCount  <= '0;
            curStart   <= '0;
            alignedEnd <= '0;
            realEnd    <= '0;
        end else begin
            if (takeJob) begin
                fifoFull <= 1'b1;
            end else if (jobStart) begin
                fifoFull <= 1'b0;
            end

            case (state)
                Init: begin
                    if (jobStart) begin
                        pushCount <= 2'd1;
                        state     <= Rasterize;
                    end
                end
                Rasterize: begin
                    if (!pushesDone) begin
                        pushCount <= pushCount + 2'd1;
                    end
                    if (batchValid) begin
                        curStart <= curStart + Step;
                    end else if (popEn) begin
                        curStart   <= headGroup.start;
                        alignedEnd <= headGroup.start + alignedCount;
                        realEnd    <= headGroup.start + headCount;
                    end else if (pushesDone) begin
                        state <= Done;
                    end
                end
                Done: begin
                    // Held here while the output side is full
                    if (finish) begin
                        state <= Init;
                    end
                end
                default: begin
                    state <= Init;
                end
            endcase
        end
    end

    // Job payload
    always_ff @(posedge clk) begin
        if (takeJob) begin
            slotJob <= job;
        end
        if (jobStart) begin
            curJob <= slotJob;
        end
    end

endmodule

//--- rtl/closestHitTracker.sv
// Closest-hit search over batches of primitive slots
// Masks slots past the real group end, keeps the nearest hit

`timescale 1ns/1ns

module closestHitTracker #(
    parameter int UnitSize = 2
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 jobStart,
    input  fixedPkg::rgb8_t                      clearColor,
    input  logic                                 batchValid,
    input  rasterPkg::primIndex_t                startPrimitive,
    input  rasterPkg::primIndex_t                endPrimitive,
    input  rasterPkg::primSlot_t [UnitSize-1:0]  primSlots,
    output rasterPkg::hitRecord_t                best
);
    import fixedPkg::*;
    import rasterPkg::*;

    // Slots left before the real end of the group
    primIndex_t span;
    hitRecord_t cand;

    assign span = endPrimitive - startPrimitive;

    // ------------------------------------------------
    // Nearest hit inside the batch
    // ------------------------------------------------
    always_comb begin
        cand.hit       = 1'b0;
        cand.t         = FixedMax;
        cand.primIndex = startPrimitive;
        cand.color     = primSlots[0].color;
        // Strict compare, lower slot wins a tie
        for (int i = 0; i < UnitSize; i++) begin
            if (primSlots[i].hit && (primIndex_t'(i) < span)
                    && (!cand.hit || primSlots[i].t < cand.t)) begin
                cand.hit       = 1'b1;
                cand.t         = primSlots[i].t;
                cand.primIndex = startPrimitive + primIndex_t'(i);
                cand.color     = primSlots[i].color;
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            best <= '{hit: 1'b0, t: FixedMax, primIndex: '0, color: '0};
        end else if (jobStart) begin
            // Miss record until something nearer shows up
            best <= '{hit: 1'b0, t: FixedMax, primIndex: '0, color: clearColor};
        end else if (batchValid && cand.hit && (cand.t < best.t)) begin
            best <= cand;
        end
    end

endmodule

//--- rtl/fragmentShader.sv
// Hit position from the closest hit distance
// Checkerboard texturing of the ground primitive
// Output fragment register and valid pulse

`timescale 1ns/1ns

module fragmentShader #(
    parameter int GroundPrim = 0
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  finish,
    input  rasterPkg::rasterJob_t curJob,
    input  rasterPkg::hitRecord_t best,
    output logic                  valid,
    output rasterPkg::fragment_t  frag
);
    import fixedPkg::*;
    import rasterPkg::*;

    vec3_t hitPos;
    rgb8_t shadeColor;
    logic onGround;
    logic darkTile;

    // origin + t * dir, product brought back to 16 fraction bits
    function automatic fixed_t axisPos(fixed_t orig, fixed_t dir, fixed_t t);
        logic signed [63:0] product;
        product = t * dir;
        return orig + fixed_t'(product >>> FixedFrac);
    endfunction

    always_comb begin
        hitPos.x = axisPos(curJob.origin.x, curJob.direction.x, best.t);
        hitPos.y = axisPos(curJob.origin.y, curJob.direction.y, best.t);
        hitPos.z = axisPos(curJob.origin.z, curJob.direction.z, best.t);
    end

    // ------------------------------------------------
    // Checkerboard on the ground, 16-unit tiles
    // ------------------------------------------------
    assign onGround = best.hit && (best.primIndex == primIndex_t'(GroundPrim));
    assign darkTile = hitPos.x[FixedFrac+4] ^ hitPos.z[FixedFrac+4];

    always_comb begin
        shadeColor = best.color;
        if (onGround && darkTile) begin
            shadeColor.red   = best.color.red >> 1;
            shadeColor.green = best.color.green >> 1;
            shadeColor.blue  = best.color.blue >> 1;
        end
    end

    // One valid per finish
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            frag.pixelX    <= curJob.pixelX;
            frag.pixelY    <= curJob.pixelY;
            frag.hit       <= best.hit;
            frag.primIndex <= best.primIndex;
            frag.hitPos    <= hitPos;
            frag.color     <= shadeColor;
        end
    end

endmodule

//--- rtl/rasterTop.sv
// Raster stage top level
// Scheduler, group queue, closest-hit tracker and shader

`timescale 1ns/1ns

module rasterTop #(
    parameter int UnitSize   = 2,
    parameter int QueueDepth = 4,
    parameter int GroundPrim = 0
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                addInput,
    input  rasterPkg::rasterJob_t               job,
    input  fixedPkg::rgb8_t                     clearColor,
    input  rasterPkg::primSlot_t [UnitSize-1:0] primSlots,
    input  logic                                outputFifoFull,
    output logic                                fifoFull,
    output rasterPkg::primIndex_t               startPrimitive,
    output rasterPkg::primIndex_t               endPrimitive,
    output logic                                valid,
    output rasterPkg::fragment_t                frag
);
    import rasterPkg::*;

    // ------------------------------------------------
    // Internal connections
    // ------------------------------------------------
    rasterJob_t curJob;
    primGroup_t pushGroup;
    primGroup_t headGroup;
    hitRecord_t best;
    logic pushEn;
    logic popEn;
    logic empty;
    logic jobStart;
    logic batchValid;
    logic finish;

    batchScheduler #(
        .UnitSize(UnitSize)
    ) scheduler (
        .clk(clk),
        .resetn(resetn),
        .addInput(addInput),
        .job(job),
        .outputFifoFull(outputFifoFull),
        .headGroup(headGroup),
        .empty(empty),
        .fifoFull(fifoFull),
        .curJob(curJob),
        .pushEn(pushEn),
        .pushGroup(pushGroup),
        .popEn(popEn),
        .jobStart(jobStart),
        .batchValid(batchValid),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .finish(finish)
    );

    primGroupQueue #(
        .QueueDepth(QueueDepth)
    ) groupQueue (
        .clk(clk),
        .resetn(resetn),
        .pushEn(pushEn),
        .pushGroup(pushGroup),
        .popEn(popEn),
        .headGroup(headGroup),
        .empty(empty)
    );

    closestHitTracker #(
        .UnitSize(UnitSize)
    ) tracker (
        .clk(clk),
        .resetn(resetn),
        .jobStart(jobStart),
        .clearColor(clearColor),
        .batchValid(batchValid),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .primSlots(primSlots),
        .best(best)
    );

    fragmentShader #(
        .GroundPrim(GroundPrim)
    ) shader (
        .clk(clk),
        .resetn(resetn),
        .finish(finish),
        .curJob(curJob),
        .best(best),
        .valid(valid),
        .frag(frag)
    );

endmodule

//--- tb/rasterTb.sv
// Testbench for the raster stage
// Clock, primitive store model, stimulus, reference model and assertions

`timescale 1ns/1ns

module rasterTb;
    import fixedPkg::*;
    import rasterPkg::*;

    localparam int UnitSize    = 2;
    localparam int GroundPrim  = 0;
    localparam int ResetCycles = 5;
    localparam int TestTotal   = 6;
    localparam int CycleLimit  = 400 * TestTotal + ResetCycles;

    logic clk;
    logic resetn;
    logic addInput;
    rasterJob_t job;
    rgb8_t clearColor;
    primSlot_t [UnitSize-1:0] primSlots;
    logic outputFifoFull;
    logic fifoFull;
    primIndex_t startPrimitive;
    primIndex_t endPrimitive;
    logic valid;
    fragment_t frag;

    primSlot_t store [32];
    fragment_t fragLog [64];
    primIndex_t endLog [64];
    int fragCount = 0;
    int fragTaken = 0;
    int fullCycles = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int cycleCount = 0;
    integer seed = 70324;

    rasterTop DUT (
        .clk(clk),
        .resetn(resetn),
        .addInput(addInput),
        .job(job),
        .clearColor(clearColor),
        .primSlots(primSlots),
        .outputFifoFull(outputFifoFull),
        .fifoFull(fifoFull),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .valid(valid),
        .frag(frag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Store answers in the same cycle, index wraps inside the array
    for (genvar i = 0; i < UnitSize; i++) begin : storeRead
        assign primSlots[i] = store[(int'(startPrimitive) + i) % 32];
    end

    // ------------------------------------------------
    // Output monitor and cycle counters
    // ------------------------------------------------
    always @(negedge clk) begin
        if (resetn && valid && fragCount < 64) begin
            fragLog[fragCount] = frag;
            endLog[fragCount] = endPrimitive;
            fragCount = fragCount + 1;
        end
    end

    always @(posedge clk) begin
        if (outputFifoFull) begin
            fullCycles <= fullCycles + 1;
        end
    end

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run timed out waiting for valid after %0d cycles", cycleCount);
        $display("Regression failed");
        $finish;
    end

    assert property (@(posedge clk) disable iff (!resetn) valid |=> !valid)
    else begin
        errorCount++;
        $display("valid stayed high for more than one cycle");
    end

    assert property (@(posedge clk) disable iff (!resetn) valid |-> !$past(outputFifoFull))
    else begin
        errorCount++;
        $display("valid rose while the output side was full");
    end

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    function automatic primGroup_t groupOf(input int start, input int count);
        primGroup_t g;
        g.start = primIndex_t'(start);
        g.count = primCount_t'(count);
        return g;
    endfunction

    function automatic vec3_t vec(input fixed_t x, input fixed_t y, input fixed_t z);
        vec3_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic primSlot_t hitSlot(input fixed_t t, input rgb8_t color);
        primSlot_t s;
        s.hit = 1'b1;
        s.t = t;
        s.color = color;
        return s;
    endfunction

    function automatic rasterJob_t buildJob(input int px, input int py, input vec3_t o,
                                            input vec3_t d, input primGroup_t leaf0,
                                            input primGroup_t leaf1);
        rasterJob_t j;
        j.pixelX = 10'(px);
        j.pixelY = 10'(py);
        j.origin = o;
        j.direction = d;
        j.leafGroups[0] = leaf0;
        j.leafGroups[1] = leaf1;
        return j;
    endfunction

    function automatic fixed_t alongRay(input fixed_t o, input fixed_t d, input fixed_t t);
        longint scaled;
        scaled = (longint'(t) * longint'(d)) >>> FixedFrac;
        return o + fixed_t'(scaled);
    endfunction

    // Real end of the last group a job walks, held until the next pop
    function automatic primIndex_t lastGroupEnd(input rasterJob_t j);
        primIndex_t groupEnd;
        groupEnd = GlobalStart + primIndex_t'(GlobalCount);
        for (int g = 0; g < 2; g++) begin
            if (j.leafGroups[g].count != '0) begin
                groupEnd = j.leafGroups[g].start + primIndex_t'(j.leafGroups[g].count);
            end
        end
        return groupEnd;
    endfunction

    // Miss fragments only carry pixel, hit flag and color
    function automatic bit fragMatches(input fragment_t e, input fragment_t a);
        if (e.pixelX !== a.pixelX || e.pixelY !== a.pixelY || e.hit !== a.hit
                || e.color !== a.color) begin
            return 1'b0;
        end
        if (e.hit && (e.primIndex !== a.primIndex || e.hitPos !== a.hitPos)) begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic clearStore();
        for (int i = 0; i < 32; i++) begin
            store[i] = '0;
        end
    endtask

    // Reference fragment: global group, then leaf 0, then leaf 1
    task automatic expectFragment(input rasterJob_t j, output fragment_t f);
        primGroup_t groups [3];
        primIndex_t idx;
        primSlot_t s;
        fixed_t bestT;
        logic found;
        primIndex_t bestIdx;
        rgb8_t color;
        groups[0] = groupOf(GlobalStart, GlobalCount);
        groups[1] = j.leafGroups[0];
        groups[2] = j.leafGroups[1];
        bestT = FixedMax;
        found = 1'b0;
        bestIdx = '0;
        color = clearColor;
        for (int g = 0; g < 3; g++) begin
            for (int k = 0; k < int'(groups[g].count); k++) begin
                idx = groups[g].start + primIndex_t'(k);
                s = store[idx % 32];
                // Only a strictly nearer hit replaces, earlier index keeps a tie
                if (s.hit && s.t < bestT) begin
                    found = 1'b1;
                    bestT = s.t;
                    bestIdx = idx;
                    color = s.color;
                end
            end
        end
        f = '0;
        f.pixelX = j.pixelX;
        f.pixelY = j.pixelY;
        f.hit = found;
        f.primIndex = bestIdx;
        f.hitPos.x = alongRay(j.origin.x, j.direction.x, bestT);
        f.hitPos.y = alongRay(j.origin.y, j.direction.y, bestT);
        f.hitPos.z = alongRay(j.origin.z, j.direction.z, bestT);
        // Checkerboard on the ground primitive
        if (found && bestIdx == primIndex_t'(GroundPrim)
                && f.hitPos.x[FixedFrac+4] != f.hitPos.z[FixedFrac+4]) begin
            color.red = color.red >> 1;
            color.green = color.green >> 1;
            color.blue = color.blue >> 1;
        end
        f.color = color;
    endtask

    // Called and returns 10 ns after a rising edge
    task automatic submitJob(input rasterJob_t j);
        addInput = 1'b1;
        job = j;
        @(negedge clk);
        while (fifoFull) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        addInput = 1'b0;
    endtask

    task automatic checkNext(input string name, input fragment_t e, input primIndex_t expEnd);
        fragment_t a;
        primIndex_t actEnd;
        wait (fragCount > fragTaken);
        a = fragLog[fragTaken];
        actEnd = endLog[fragTaken];
        fragTaken++;
        checkCount++;
        assert (fragMatches(e, a))
        else begin
            errorCount++;
            $write("[ERROR] %s expected hit %0b prim %0d color %h pos %h,", name, e.hit,
                   e.primIndex, e.color, e.hitPos);
            $display(" actual hit %0b prim %0d color %h pos %h", a.hit, a.primIndex,
                     a.color, a.hitPos);
        end
        assert (actEnd == expEnd)
        else begin
            errorCount++;
            $display("[ERROR] %s expected endPrimitive %0d actual %0d", name, expEnd, actEnd);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic runJob(input string name, input rasterJob_t j);
        fragment_t e;
        expectFragment(j, e);
        submitJob(j);
        checkNext(name, e, lastGroupEnd(j));
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        $display("Test %0d %s: %s", testCount, name,
                 (errorCount == startErrors) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    initial begin
        rasterJob_t jobA;
        rasterJob_t jobB;
        fragment_t expA;
        fragment_t expB;
        vec3_t o;
        vec3_t d;
        int startErrors;
        resetn = 1'b0;
        addInput = 1'b0;
        job = '0;
        clearColor = 24'h10_20_30;
        outputFifoFull = 1'b0;
        clearStore();
        repeat (ResetCycles) @(posedge clk);
        #10;
        resetn = 1'b1;
        @(posedge clk);
        #10;

        startErrors = errorCount;
        store[1] = hitSlot(32'sh0002_0000, 24'h11_22_33);
        runJob("singleHit", buildJob(5, 7, vec(32'sh0001_0000, 32'sh0002_0000, 32'sh0003_0000),
               vec(32'sh0000_8000, -32'sh0001_0000, 32'sh0002_0000), groupOf(0, 0),
               groupOf(0, 0)));
        finishTest("singleHit", startErrors);

        // Nearer hits sit just past the end of each group
        startErrors = errorCount;
        clearStore();
        store[2] = hitSlot(32'sh0006_0000, 24'h20_20_20);
        store[3] = hitSlot(32'sh0000_8000, 24'hff_00_00);
        store[9] = hitSlot(32'sh0003_0000, 24'h00_90_40);
        store[11] = hitSlot(32'sh0001_0000, 24'hff_00_00);
        store[13] = hitSlot(32'sh0004_0000, 24'h00_00_c0);
        store[14] = hitSlot(32'sh0000_4000, 24'hff_00_00);
        runJob("maskedClosest", buildJob(100, 200, vec(0, 32'sh0001_0000, 0),
               vec(32'sh0001_0000, 0, -32'sh0000_8000), groupOf(8, 3), groupOf(13, 1)));
        finishTest("maskedClosest", startErrors);

        startErrors = errorCount;
        clearStore();
        store[3] = hitSlot(32'sh0001_0000, 24'hff_ff_ff);
        clearColor = 24'h20_30_40;
        runJob("miss", buildJob(1, 2, vec(0, 0, 0), vec(0, 0, 32'sh0001_0000),
               groupOf(0, 0), groupOf(0, 0)));
        finishTest("miss", startErrors);

        // Bit 20 of x and z differ in the first job and agree in the second
        startErrors = errorCount;
        clearStore();
        store[0] = hitSlot(32'sh0001_0000, 24'h80_c0_fe);
        d = vec(0, -32'sh0001_0000, 0);
        runJob("checkerboard", buildJob(3, 3, vec(32'sh0010_0000, 32'sh0002_0000, 0), d,
               groupOf(0, 0), groupOf(0, 0)));
        runJob("checkerboard", buildJob(4, 3, vec(32'sh0010_0000, 32'sh0002_0000,
               32'sh0010_0000), d, groupOf(0, 0), groupOf(0, 0)));
        finishTest("checkerboard", startErrors);

        startErrors = errorCount;
        clearStore();
        store[2] = hitSlot(32'sh0002_0000, 24'h44_55_66);
        store[6] = hitSlot(32'sh0001_0000, 24'h77_88_99);
        o = vec(32'sh0001_0000, 0, 32'sh0001_0000);
        jobA = buildJob(10, 11, o, d, groupOf(0, 0), groupOf(0, 0));
        jobB = buildJob(12, 13, o, d, groupOf(5, 2), groupOf(0, 0));
        expectFragment(jobA, expA);
        expectFragment(jobB, expB);
        outputFifoFull = 1'b1;
        fullCycles = 0;
        submitJob(jobA);
        submitJob(jobB);
        // Third job while the slot holds B must be dropped
        addInput = 1'b1;
        job = buildJob(900, 901, o, d, groupOf(6, 1), groupOf(0, 0));
        repeat (3) begin
            @(negedge clk);
            assert (fifoFull)
            else begin
                errorCount++;
                $display("Job slot opened while a job waited on the output side");
            end
            @(posedge clk);
            #10;
        end
        addInput = 1'b0;
        // Released after 20 cycles high
        while (fullCycles < 19) begin
            @(negedge clk);
        end
        assert (fragCount == fragTaken)
        else begin
            errorCount++;
            $display("A fragment came out while the output side was full");
        end
        @(posedge clk);
        #10;
        outputFifoFull = 1'b0;
        checkNext("backPressure", expA, lastGroupEnd(jobA));
        checkNext("backPressure", expB, lastGroupEnd(jobB));
        finishTest("backPressure", startErrors);

        startErrors = errorCount;
        for (int n = 0; n < 20; n++) begin
            for (int i = 0; i < 32; i++) begin
                store[i].hit = (($random(seed) & 3) == 0);
                store[i].t = $random(seed) & 32'h000f_ffff;
                store[i].color = $random(seed);
            end
            clearColor = $random(seed);
            o = vec($random(seed) >>> 8, $random(seed) >>> 8, $random(seed) >>> 8);
            d = vec($random(seed) >>> 12, $random(seed) >>> 12, $random(seed) >>> 12);
            runJob("random", buildJob($random(seed) & 1023, $random(seed) & 1023, o, d,
                   groupOf($random(seed) & 31, $random(seed) & 7),
                   groupOf($random(seed) & 31, $random(seed) & 7)));
        end
        finishTest("random", startErrors);

        assert (fragCount == fragTaken)
        else begin
            errorCount++;
            $display("More fragments came out than jobs were accepted");
        end
        $display("Tests run: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/fixedPkg.sv
rtl/rasterPkg.sv
rtl/primGroupQueue.sv
rtl/batchScheduler.sv
rtl/closestHitTracker.sv
rtl/fragmentShader.sv
rtl/rasterTop.sv
tb/rasterTb.sv
